// File: hdl/raycast_pkg.sv
package raycast_pkg;

  // Screen position counter, used for both hpos and vpos
  typedef logic [9:0] pos_t;
  // Pixel colour packed as {b1,b0,g1,g0,r1,r0}
  typedef logic [5:0] rgb_t;
  // Texture coordinate, u or v, 64 texels per axis
  typedef logic [5:0] texc_t;
  typedef logic [1:0] wall_t;
  // Wall half-height in pixels
  typedef logic [9:0] size_t;
  // Signed fixed point with FIX_FRAC fraction bits
  typedef logic signed [17:0] fix_t;
  // Texture QSPI sequence step, follows hpos
  typedef logic [9:0] tspi_state_t;

  // Horizontal timing, 640 visible columns
  localparam pos_t H_VIEW       = 10'd640;
  localparam pos_t H_SYNC_START = 10'd656;
  localparam pos_t H_SYNC_END   = 10'd752;
  localparam pos_t H_TOTAL      = 10'd800;

  // Vertical timing, 480 visible lines
  localparam pos_t V_VIEW       = 10'd480;
  localparam pos_t V_SYNC_START = 10'd490;
  localparam pos_t V_SYNC_END   = 10'd492;
  localparam pos_t V_TOTAL      = 10'd525;

  // Screen centre on the hpos axis, floor/sky split
  localparam pos_t HALF_SIZE = H_VIEW >> 1;

  // QSPI read stream lengths, in SCLK cycles
  localparam tspi_state_t TSPI_CMD_LEN      = 10'd8;
  localparam tspi_state_t TSPI_ADDR_LEN     = 10'd24;
  localparam tspi_state_t TSPI_DUMMY_LEN    = 10'd8;
  localparam tspi_state_t TSPI_PREAMBLE_LEN = TSPI_CMD_LEN + TSPI_ADDR_LEN + TSPI_DUMMY_LEN;
  localparam int unsigned TEXEL_COUNT       = 64;
  // Two nibbles per texel byte
  localparam tspi_state_t TSPI_READ_LEN     = tspi_state_t'(TEXEL_COUNT * 2);
  localparam tspi_state_t TSPI_STREAM_LEN   = TSPI_PREAMBLE_LEN + TSPI_READ_LEN;
  // Stream starts so that data arrives right after the visible area
  localparam pos_t        TSPI_HPOS_START   = H_VIEW - TSPI_PREAMBLE_LEN;

  // Quad output fast read
  localparam logic [7:0] TSPI_CMD = 8'h6B;

  localparam int FIX_FRAC = 10;

endpackage

// File: hdl/raycast_row_top.sv
`timescale 1ns/100ps

module raycast_row_top (
  input  logic               clk,
  input  logic               reset,
  // Wall slice descriptor intake
  input  logic               i_slice_valid,
  output logic               o_slice_ready,
  input  raycast_pkg::wall_t i_slice_wall,
  input  logic               i_slice_side,
  input  raycast_pkg::texc_t i_slice_texu,
  input  raycast_pkg::size_t i_slice_size,
  input  raycast_pkg::fix_t  i_slice_texa,
  input  raycast_pkg::fix_t  i_slice_texvinit,
  // Background colours
  input  raycast_pkg::rgb_t  i_sky,
  input  raycast_pkg::rgb_t  i_floor,
  // Texture flash, QSPI master
  output logic               o_tex_csb,
  output logic               o_tex_sclk,
  output logic               o_tex_out0,
  // io0 direction, high means input
  output logic               o_tex_oeb0,
  input  logic [3:0]         i_tex_in,
  // VGA
  output logic               o_hsync_n,
  output logic               o_vsync_n,
  output raycast_pkg::rgb_t  o_rgb,
  output logic               o_hblank,
  output logic               o_vblank,
  output raycast_pkg::pos_t  o_hpos,
  output raycast_pkg::pos_t  o_vpos
);

  logic               hsync;
  logic               vsync;
  logic               hmax;
  logic               visible;
  logic               capture_en;
  logic               capture_odd;
  logic               fetch_take;
  raycast_pkg::wall_t fetch_wall;
  logic               fetch_side;
  raycast_pkg::texc_t fetch_texu;
  logic               cur_valid;
  raycast_pkg::size_t cur_size;
  raycast_pkg::fix_t  cur_texa;
  raycast_pkg::fix_t  cur_texvinit;
  raycast_pkg::texc_t texv;
  raycast_pkg::rgb_t  texel;

  vga_timing u_vga_timing (
    .clk       (clk),
    .reset     (reset),
    .o_hpos    (o_hpos),
    .o_vpos    (o_vpos),
    .o_hsync   (hsync),
    .o_vsync   (vsync),
    .o_hmax    (hmax),
    .o_vmax    (),
    .o_visible (visible)
  );

  // Syncs are active low on the connector
  assign o_hsync_n = !hsync;
  assign o_vsync_n = !vsync;
  assign o_hblank  = (o_hpos >= raycast_pkg::H_VIEW);
  assign o_vblank  = (o_vpos >= raycast_pkg::V_VIEW);

  // Flash clock runs continuously at full rate
  // Data out changes on the rising clk edge, flash samples on the next SCLK rise
  assign o_tex_sclk = !clk;

  tex_fetch_ctrl u_tex_fetch_ctrl (
    .clk           (clk),
    .reset         (reset),
    .i_hpos        (o_hpos),
    .i_wall        (fetch_wall),
    .i_side        (fetch_side),
    .i_texu        (fetch_texu),
    .o_tex_csb     (o_tex_csb),
    .o_tex_oeb0    (o_tex_oeb0),
    .o_tex_out0    (o_tex_out0),
    .o_capture_en  (capture_en),
    .o_capture_odd (capture_odd),
    .o_fetch_take  (fetch_take)
  );

  slice_queue u_slice_queue (
    .clk              (clk),
    .reset            (reset),
    .i_slice_valid    (i_slice_valid),
    .i_slice_wall     (i_slice_wall),
    .i_slice_side     (i_slice_side),
    .i_slice_texu     (i_slice_texu),
    .i_slice_size     (i_slice_size),
    .i_slice_texa     (i_slice_texa),
    .i_slice_texvinit (i_slice_texvinit),
    .i_fetch_take     (fetch_take),
    .i_hmax           (hmax),
    .o_slice_ready    (o_slice_ready),
    .o_fetch_wall     (fetch_wall),
    .o_fetch_side     (fetch_side),
    .o_fetch_texu     (fetch_texu),
    .o_cur_valid      (cur_valid),
    .o_cur_size       (cur_size),
    .o_cur_texa       (cur_texa),
    .o_cur_texvinit   (cur_texvinit)
  );

  // io3 carries no colour data
  texel_buffer u_texel_buffer (
    .clk           (clk),
    .i_capture_en  (capture_en),
    .i_capture_odd (capture_odd),
    .i_tex_in      (i_tex_in[2:0]),
    .i_texv        (texv),
    .o_texel       (texel)
  );

  row_shader u_row_shader (
    .clk         (clk),
    .reset       (reset),
    .i_hpos      (o_hpos),
    .i_hmax      (hmax),
    .i_visible   (visible),
    .i_cur_valid (cur_valid),
    .i_size      (cur_size),
    .i_texa      (cur_texa),
    .i_texvinit  (cur_texvinit),
    .i_texel     (texel),
    .i_sky       (i_sky),
    .i_floor     (i_floor),
    .o_texv      (texv),
    .o_rgb       (o_rgb)
  );

endmodule

// File: hdl/row_shader.sv
`timescale 1ns/100ps

module row_shader (
  input  logic               clk,
  input  logic               reset,
  input  raycast_pkg::pos_t  i_hpos,
  input  logic               i_hmax,
  input  logic               i_visible,
  input  logic               i_cur_valid,
  input  raycast_pkg::size_t i_size,
  input  raycast_pkg::fix_t  i_texa,
  input  raycast_pkg::fix_t  i_texvinit,
  input  raycast_pkg::rgb_t  i_texel,
  input  raycast_pkg::rgb_t  i_sky,
  input  raycast_pkg::rgb_t  i_floor,
  output raycast_pkg::texc_t o_texv,
  output raycast_pkg::rgb_t  o_rgb
);

  // Step accumulator, holds h*texa during column h
  raycast_pkg::fix_t tex_acc;
  // Texture v in fixed point, relative to the slice start
  raycast_pkg::fix_t tex_vv;
  logic              right_half;
  raycast_pkg::pos_t centre_dist;
  logic              in_span;

  always_ff @(posedge clk) begin
    if (reset) begin
      tex_acc <= '0;
    end else if (i_hmax) begin
      // Restart for column 0 of the next line
      tex_acc <= '0;
    end else begin
      tex_acc <= tex_acc + i_texa;
    end
  end

  assign tex_vv = tex_acc + i_texvinit;

  // Integer part is the texel index
  // Negative v is clamped to the first texel
  assign o_texv = tex_vv[$bits(raycast_pkg::fix_t)-1]
    ? '0
    : tex_vv[raycast_pkg::FIX_FRAC +: $bits(raycast_pkg::texc_t)];

  // Distance from the screen centre, no signed math needed
  assign right_half  = (i_hpos >= raycast_pkg::HALF_SIZE);
  assign centre_dist = right_half
    ? i_hpos - raycast_pkg::HALF_SIZE
    : raycast_pkg::HALF_SIZE - i_hpos;

  // Span covers HALF_SIZE-size up to HALF_SIZE+size-1
  assign in_span = i_cur_valid &&
    (right_half ? (centre_dist < i_size) : (centre_dist <= i_size));

  // Final colour, black outside the visible area
  always_comb begin
    if (!i_visible) begin
      o_rgb = '0;
    end else if (in_span) begin
      o_rgb = i_texel;
    end else if (!right_half) begin
      o_rgb = i_floor;
    end else begin
      o_rgb = i_sky;
    end
  end

endmodule

// File: hdl/slice_queue.sv
`timescale 1ns/100ps

module slice_queue (
  input  logic               clk,
  input  logic               reset,
  input  logic               i_slice_valid,
  input  raycast_pkg::wall_t i_slice_wall,
  input  logic               i_slice_side,
  input  raycast_pkg::texc_t i_slice_texu,
  input  raycast_pkg::size_t i_slice_size,
  input  raycast_pkg::fix_t  i_slice_texa,
  input  raycast_pkg::fix_t  i_slice_texvinit,
  input  logic               i_fetch_take,
  input  logic               i_hmax,
  output logic               o_slice_ready,
  output raycast_pkg::wall_t o_fetch_wall,
  output logic               o_fetch_side,
  output raycast_pkg::texc_t o_fetch_texu,
  output logic               o_cur_valid,
  output raycast_pkg::size_t o_cur_size,
  output raycast_pkg::fix_t  o_cur_texa,
  output raycast_pkg::fix_t  o_cur_texvinit
);

  // Next slot, written by the intake
  logic               next_valid;
  raycast_pkg::wall_t next_wall;
  logic               next_side;
  raycast_pkg::texc_t next_texu;
  raycast_pkg::size_t next_size;
  raycast_pkg::fix_t  next_texa;
  raycast_pkg::fix_t  next_texvinit;

  // Fetched slot, address fields go straight out to the QSPI sequencer
  logic               fetch_valid;
  raycast_pkg::size_t fetch_size;
  raycast_pkg::fix_t  fetch_texa;
  raycast_pkg::fix_t  fetch_texvinit;

  logic accept;
  logic take;

  assign o_slice_ready = !next_valid;
  assign accept        = i_slice_valid && o_slice_ready;
  // An empty next slot leaves the fetched slice as is, so the line repeats
  assign take          = i_fetch_take && next_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      next_valid  <= 1'b0;
      fetch_valid <= 1'b0;
      o_cur_valid <= 1'b0;
    end else begin
      if (accept) begin
        next_valid <= 1'b1;
      end else if (take) begin
        next_valid <= 1'b0;
      end
      if (take) begin
        fetch_valid <= 1'b1;
      end
      // Texture streamed this line is drawn on the next one
      if (i_hmax) begin
        o_cur_valid <= fetch_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      next_wall     <= i_slice_wall;
      next_side     <= i_slice_side;
      next_texu     <= i_slice_texu;
      next_size     <= i_slice_size;
      next_texa     <= i_slice_texa;
      next_texvinit <= i_slice_texvinit;
    end
    if (take) begin
      o_fetch_wall   <= next_wall;
      o_fetch_side   <= next_side;
      o_fetch_texu   <= next_texu;
      fetch_size     <= next_size;
      fetch_texa     <= next_texa;
      fetch_texvinit <= next_texvinit;
    end
    if (i_hmax) begin
      o_cur_size     <= fetch_size;
      o_cur_texa     <= fetch_texa;
      o_cur_texvinit <= fetch_texvinit;
    end
  end

  // A full next slot holds its descriptor until it is taken
  a_next_hold: assert property (@(posedge clk) disable iff (reset)
    next_valid |=> (!next_valid || $stable({next_wall, next_side, next_texu,
                                            next_size, next_texa, next_texvinit})));

endmodule

// File: hdl/tex_fetch_ctrl.sv
`timescale 1ns/100ps

module tex_fetch_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  raycast_pkg::pos_t  i_hpos,
  input  raycast_pkg::wall_t i_wall,
  input  logic               i_side,
  input  raycast_pkg::texc_t i_texu,
  output logic               o_tex_csb,
  output logic               o_tex_oeb0,
  output logic               o_tex_out0,
  output logic               o_capture_en,
  output logic               o_capture_odd,
  output logic               o_fetch_take
);

  raycast_pkg::tspi_state_t tspi_state;
  logic [23:0]              slice_addr;
  logic                     in_stream;

  // Sequence step tracks hpos, wraps modulo 1024
  assign tspi_state = i_hpos - raycast_pkg::TSPI_HPOS_START;

  // Slice base address in flash
  //   bits 5:0   texel within the slice
  //   bits 11:6  texu
  //   bit 12     side
  //   bits 14:13 wall id
  assign slice_addr = {9'd0, i_wall, i_side, i_texu, 6'd0};

  assign in_stream = (tspi_state < raycast_pkg::TSPI_STREAM_LEN);

  // Chip select held low for the whole read, active low
  assign o_tex_csb = !in_stream;

  // io0 turns around to input from the dummy cycles on
  assign o_tex_oeb0 = (tspi_state >= raycast_pkg::TSPI_CMD_LEN + raycast_pkg::TSPI_ADDR_LEN);

  // Serial bit on io0, MSB first
  // For states below 8, 7-state is the inverted low 3 bits
  // For states 8 to 31, 31-state is the inverted low 5 bits
  always_comb begin
    if (tspi_state < raycast_pkg::TSPI_CMD_LEN) begin
      o_tex_out0 = raycast_pkg::TSPI_CMD[~tspi_state[2:0]];
    end else if (tspi_state < raycast_pkg::TSPI_CMD_LEN + raycast_pkg::TSPI_ADDR_LEN) begin
      o_tex_out0 = slice_addr[~tspi_state[4:0]];
    end else begin
      o_tex_out0 = 1'b0;
    end
  end

  // Flash presents nibbles after the preamble
  assign o_capture_en = (tspi_state >= raycast_pkg::TSPI_PREAMBLE_LEN) && in_stream;
  // Odd step carries the high nibble of each byte
  assign o_capture_odd = tspi_state[0];

  // One cycle pulse during the column before the stream,
  // so the fetched slice is in place for the address phase
  always_ff @(posedge clk) begin
    if (reset) begin
      o_fetch_take <= 1'b0;
    end else begin
      o_fetch_take <= (i_hpos == raycast_pkg::TSPI_HPOS_START - 10'd2);
    end
  end

  // Capture only inside the chip-select window
  a_capture_in_cs: assert property (@(posedge clk) disable iff (reset)
    o_capture_en |-> !o_tex_csb);

  // Stream begins right after the fetch pulse
  a_take_then_cs: assert property (@(posedge clk) disable iff (reset)
    o_fetch_take |=> (!o_tex_csb && (tspi_state == '0)));

endmodule

// File: hdl/texel_buffer.sv
`timescale 1ns/100ps

module texel_buffer (
  input  logic               clk,
  input  logic               i_capture_en,
  input  logic               i_capture_odd,
  input  logic [2:0]         i_tex_in,
  input  raycast_pkg::texc_t i_texv,
  output raycast_pkg::rgb_t  o_texel
);

  // One bit plane per colour bit, indexed by texel
  logic [raycast_pkg::TEXEL_COUNT-1:0] tex_r0;
  logic [raycast_pkg::TEXEL_COUNT-1:0] tex_r1;
  logic [raycast_pkg::TEXEL_COUNT-1:0] tex_g0;
  logic [raycast_pkg::TEXEL_COUNT-1:0] tex_g1;
  logic [raycast_pkg::TEXEL_COUNT-1:0] tex_b0;
  logic [raycast_pkg::TEXEL_COUNT-1:0] tex_b1;

  // Flash data is stable at the rising SCLK edge, i.e. falling clk
  // Byte layout XBGRXBGR, low nibble first, io3 not used
  // Shifting in at the MSB leaves byte k at bit k after 64 bytes
  always_ff @(negedge clk) begin
    if (i_capture_en) begin
      if (!i_capture_odd) begin
        // Low nibble, colour LSBs
        tex_r0 <= {i_tex_in[0], tex_r0[raycast_pkg::TEXEL_COUNT-1:1]};
        tex_g0 <= {i_tex_in[1], tex_g0[raycast_pkg::TEXEL_COUNT-1:1]};
        tex_b0 <= {i_tex_in[2], tex_b0[raycast_pkg::TEXEL_COUNT-1:1]};
      end else begin
        // High nibble, colour MSBs
        tex_r1 <= {i_tex_in[0], tex_r1[raycast_pkg::TEXEL_COUNT-1:1]};
        tex_g1 <= {i_tex_in[1], tex_g1[raycast_pkg::TEXEL_COUNT-1:1]};
        tex_b1 <= {i_tex_in[2], tex_b1[raycast_pkg::TEXEL_COUNT-1:1]};
      end
    end
  end

  // Texel lookup at v
  assign o_texel = {
    tex_b1[i_texv], tex_b0[i_texv],
    tex_g1[i_texv], tex_g0[i_texv],
    tex_r1[i_texv], tex_r0[i_texv]
  };

endmodule

// File: hdl/vga_timing.sv
`timescale 1ns/100ps

module vga_timing (
  input  logic              clk,
  input  logic              reset,
  output raycast_pkg::pos_t o_hpos,
  output raycast_pkg::pos_t o_vpos,
  output logic              o_hsync,
  output logic              o_vsync,
  output logic              o_hmax,
  output logic              o_vmax,
  output logic              o_visible
);

  logic              h_wrap;
  raycast_pkg::pos_t h_next;
  raycast_pkg::pos_t v_next;

  // Decode below is registered from the next counter values
  // so every strobe lines up with the hpos/vpos it belongs to
  always_comb begin
    h_wrap = (o_hpos == raycast_pkg::H_TOTAL - 10'd1);
    h_next = h_wrap ? '0 : o_hpos + 10'd1;
    if (!h_wrap) begin
      v_next = o_vpos;
    end else if (o_vpos == raycast_pkg::V_TOTAL - 10'd1) begin
      v_next = '0;
    end else begin
      v_next = o_vpos + 10'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_hpos    <= '0;
      o_vpos    <= '0;
      o_hsync   <= 1'b0;
      o_vsync   <= 1'b0;
      o_hmax    <= 1'b0;
      o_vmax    <= 1'b0;
      // Position 0,0 is on screen
      o_visible <= 1'b1;
    end else begin
      o_hpos    <= h_next;
      o_vpos    <= v_next;
      o_hsync   <= (h_next >= raycast_pkg::H_SYNC_START) && (h_next < raycast_pkg::H_SYNC_END);
      o_vsync   <= (v_next >= raycast_pkg::V_SYNC_START) && (v_next < raycast_pkg::V_SYNC_END);
      // End of line strobe on the last column
      o_hmax    <= (h_next == raycast_pkg::H_TOTAL - 10'd1);
      // End of frame strobe on the last column of the last line
      o_vmax    <= (h_next == raycast_pkg::H_TOTAL - 10'd1) &&
                   (v_next == raycast_pkg::V_TOTAL - 10'd1);
      o_visible <= (h_next < raycast_pkg::H_VIEW) && (v_next < raycast_pkg::V_VIEW);
    end
  end

  // Horizontal count wraps before the line total
  a_hpos_range: assert property (@(posedge clk) disable iff (reset)
    o_hpos < raycast_pkg::H_TOTAL);

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_raycast_row \
  -f tb.f -o sim_raycast_row
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_raycast_row)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: tb.f
hdl/raycast_pkg.sv
hdl/vga_timing.sv
hdl/tex_fetch_ctrl.sv
hdl/slice_queue.sv
hdl/texel_buffer.sv
hdl/row_shader.sv
hdl/raycast_row_top.sv
verification/tb_raycast_row.sv

// File: verification/slice_stim.hex
// word 0 sky, word 1 floor; per slice: wall side texu size texa texvinit,
// then eight texel words with byte k at bits 8*(k%8) of word k/8
2d 12
// slice 0, plain span
1 0 15 64 a0 400
1122334455667788 99aabbccddeeff00 0f1e2d3c4b5a6978 8796a5b4c3d2e1f0
13579bdf02468ace fdb97531eca86420 5a5aa5a5c3c33c3c 0123456789abcdef
// slice 1, negative texvinit for the clamp
2 1 2a c8 64 3b1e0
fedcba9876543210 7766554433221100 a1b2c3d4e5f60718 293a4b5c6d7e8f90
1f2e3d4c5b6a7988 8899aabbccddeeff 6d2a91f4037bc85e 48e17a0cd3956b2f
// slice 2, span covers the whole width
3 1 3f 140 3c 1000
b7403e9c15d26a8f 2c91e74b05f83ad6 9e06c4712fb85d3a 71d83c0a96e4b25f
0a5ce3917bd4268f e4179b3c60a82df5 835f0cd6a1e927b4 5fb2864d1c0e93a7
// slice 3, narrow span with a steep step
0 0 1 20 c8 800
d19c07e4a36b52f8 3a7f15c8e0924db6 c4e860b21f7d9a35 6e0b9d423c81f5a7
f2583ac19d46be07 18d7e5b4a2c30f96 ab96f03d5e1c4782 07c4b5a96e3d21f8

// File: verification/tb_raycast_row.sv
`timescale 1ns/100ps

module tb_raycast_row;

  localparam int NUM_REC = 4;
  // Six descriptor words, then eight words of texel bytes
  localparam int REC_WORDS = 14;
  localparam int STIM_WORDS = 2 + NUM_REC * REC_WORDS;
  // One whole frame plus a few lines, so vsync is covered
  localparam int RUN_LINES = 530;
  localparam int ACCEPT_TIMEOUT = 2000;
  localparam int RUN_TIMEOUT = RUN_LINES * 800 + 1000;

  logic               clk;
  logic               reset;
  logic               i_slice_valid;
  logic               o_slice_ready;
  raycast_pkg::wall_t i_slice_wall;
  logic               i_slice_side;
  raycast_pkg::texc_t i_slice_texu;
  raycast_pkg::size_t i_slice_size;
  raycast_pkg::fix_t  i_slice_texa;
  raycast_pkg::fix_t  i_slice_texvinit;
  raycast_pkg::rgb_t  i_sky;
  raycast_pkg::rgb_t  i_floor;
  logic               o_tex_csb;
  logic               o_tex_sclk;
  logic               o_tex_out0;
  logic               o_tex_oeb0;
  logic [3:0]         i_tex_in;
  logic               o_hsync_n;
  logic               o_vsync_n;
  raycast_pkg::rgb_t  o_rgb;
  logic               o_hblank;
  logic               o_vblank;
  raycast_pkg::pos_t  o_hpos;
  raycast_pkg::pos_t  o_vpos;

  // Stimulus records
  logic [63:0]        stim_mem [0:STIM_WORDS-1];
  raycast_pkg::wall_t rec_wall [NUM_REC];
  logic               rec_side [NUM_REC];
  raycast_pkg::texc_t rec_texu [NUM_REC];
  raycast_pkg::size_t rec_size [NUM_REC];
  raycast_pkg::fix_t  rec_texa [NUM_REC];
  raycast_pkg::fix_t  rec_vinit [NUM_REC];
  logic [7:0]         rec_tex [NUM_REC][64];
  raycast_pkg::rgb_t  sky_rgb;
  raycast_pkg::rgb_t  floor_rgb;

  // Reference model of the next, fetched and current slots
  raycast_pkg::pos_t  exp_h;
  raycast_pkg::pos_t  exp_v;
  raycast_pkg::pos_t  prev_h;
  int                 line_count;
  logic               next_full;
  int                 next_idx;
  logic               fetched_valid;
  int                 fetched_idx;
  logic               cur_valid;
  int                 cur_idx;
  int                 offer_idx;
  logic               accepted;
  logic               last_ready;
  logic [31:0]        out_bits;
  logic [31:0]        rnd;

  raycast_row_top uut (
    .clk              (clk),
    .reset            (reset),
    .i_slice_valid    (i_slice_valid),
    .o_slice_ready    (o_slice_ready),
    .i_slice_wall     (i_slice_wall),
    .i_slice_side     (i_slice_side),
    .i_slice_texu     (i_slice_texu),
    .i_slice_size     (i_slice_size),
    .i_slice_texa     (i_slice_texa),
    .i_slice_texvinit (i_slice_texvinit),
    .i_sky            (i_sky),
    .i_floor          (i_floor),
    .o_tex_csb        (o_tex_csb),
    .o_tex_sclk       (o_tex_sclk),
    .o_tex_out0       (o_tex_out0),
    .o_tex_oeb0       (o_tex_oeb0),
    .i_tex_in         (i_tex_in),
    .o_hsync_n        (o_hsync_n),
    .o_vsync_n        (o_vsync_n),
    .o_rgb            (o_rgb),
    .o_hblank         (o_hblank),
    .o_vblank         (o_vblank),
    .o_hpos           (o_hpos),
    .o_vpos           (o_vpos)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic halt_on_failure;
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failing check");
  endtask

  task automatic report_mismatch(input string test_name, input int expected, input int actual);
    $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
    halt_on_failure();
  endtask

  task automatic report_problem(input string what);
    $display("[ERROR] %s", what);
    halt_on_failure();
  endtask

  task automatic load_stim;
    int base;
    int r;
    int k;
    $readmemh("verification/slice_stim.hex", stim_mem);
    sky_rgb   = stim_mem[0][5:0];
    floor_rgb = stim_mem[1][5:0];
    for (r = 0; r < NUM_REC; r++) begin
      base         = 2 + r * REC_WORDS;
      rec_wall[r]  = stim_mem[base][1:0];
      rec_side[r]  = stim_mem[base+1][0];
      rec_texu[r]  = stim_mem[base+2][5:0];
      rec_size[r]  = stim_mem[base+3][9:0];
      rec_texa[r]  = stim_mem[base+4][17:0];
      rec_vinit[r] = stim_mem[base+5][17:0];
      // Byte k sits in word k/8 with the least significant byte first
      for (k = 0; k < 64; k++) begin
        rec_tex[r][k] = stim_mem[base + 6 + k / 8][8 * (k % 8) +: 8];
      end
    end
  endtask

  // Texel byte is XBGRXBGR and the low nibble holds the colour LSBs
  function automatic raycast_pkg::rgb_t texel_colour(input logic [7:0] b);
    return {b[6], b[2], b[5], b[1], b[4], b[0]};
  endfunction

  function automatic raycast_pkg::rgb_t expected_pixel(input raycast_pkg::pos_t h,
                                                       input raycast_pkg::pos_t v);
    int lo;
    int hi;
    int acc;
    int tv;
    if (h >= raycast_pkg::H_VIEW || v >= raycast_pkg::V_VIEW) begin
      return '0;
    end
    lo = int'(raycast_pkg::HALF_SIZE) - int'(rec_size[cur_idx]);
    hi = int'(raycast_pkg::HALF_SIZE) + int'(rec_size[cur_idx]) - 1;
    if (cur_valid && int'(h) >= lo && int'(h) <= hi) begin
      acc = int'(rec_vinit[cur_idx]) + int'(h) * int'(rec_texa[cur_idx]);
      // Negative v clamps to texel 0
      // Otherwise the index is integer bits 15:10
      tv = (acc < 0) ? 0 : (acc >> 10) % 64;
      return texel_colour(rec_tex[cur_idx][tv]);
    end
    if (h < raycast_pkg::HALF_SIZE) begin
      return floor_rgb;
    end
    return sky_rgb;
  endfunction

  task automatic check_outputs;
    logic              exp_bit;
    logic [31:0]       exp_bits;
    raycast_pkg::rgb_t exp_rgb;
    assert (o_hpos == exp_h) else report_mismatch("hpos", int'(exp_h), int'(o_hpos));
    assert (o_vpos == exp_v) else report_mismatch("vpos", int'(exp_v), int'(o_vpos));
    exp_bit = !(exp_h >= raycast_pkg::H_SYNC_START && exp_h < raycast_pkg::H_SYNC_END);
    assert (o_hsync_n == exp_bit)
      else report_mismatch("hsync_n", int'(exp_bit), int'(o_hsync_n));
    exp_bit = !(exp_v >= raycast_pkg::V_SYNC_START && exp_v < raycast_pkg::V_SYNC_END);
    assert (o_vsync_n == exp_bit)
      else report_mismatch("vsync_n", int'(exp_bit), int'(o_vsync_n));
    exp_bit = (exp_h >= raycast_pkg::H_VIEW);
    assert (o_hblank == exp_bit) else report_mismatch("hblank", int'(exp_bit), int'(o_hblank));
    exp_bit = (exp_v >= raycast_pkg::V_VIEW);
    assert (o_vblank == exp_bit) else report_mismatch("vblank", int'(exp_bit), int'(o_vblank));
    // Flash clock is the inverted clk, low while clk is high
    assert (o_tex_sclk == 1'b0) else report_mismatch("tex_sclk", 0, int'(o_tex_sclk));
    // Chip select low from hpos 600 through 767
    exp_bit = !(exp_h >= raycast_pkg::TSPI_HPOS_START &&
                exp_h < raycast_pkg::TSPI_HPOS_START + raycast_pkg::TSPI_STREAM_LEN);
    assert (o_tex_csb == exp_bit)
      else report_mismatch("tex_csb", int'(exp_bit), int'(o_tex_csb));
    // io0 is driven only for command and address and released at hpos 632
    exp_bit = !(exp_h >= raycast_pkg::TSPI_HPOS_START &&
                exp_h < raycast_pkg::TSPI_HPOS_START + 10'd32);
    assert (o_tex_oeb0 == exp_bit)
      else report_mismatch("tex_oeb0", int'(exp_bit), int'(o_tex_oeb0));
    if (exp_h >= raycast_pkg::TSPI_HPOS_START &&
        exp_h < raycast_pkg::TSPI_HPOS_START + 10'd32) begin
      out_bits = {out_bits[30:0], o_tex_out0};
    end
    if (exp_h == raycast_pkg::TSPI_HPOS_START + 10'd32 && fetched_valid) begin
      exp_bits = {8'h6B, 9'd0, rec_wall[fetched_idx], rec_side[fetched_idx],
                  rec_texu[fetched_idx], 6'd0};
      assert (out_bits == exp_bits) else report_mismatch("qspi preamble", exp_bits, out_bits);
    end
    assert (o_slice_ready == !next_full)
      else report_mismatch("slice_ready", int'(!next_full), int'(o_slice_ready));
    assert (!(o_slice_ready && !last_ready) || prev_h == raycast_pkg::TSPI_HPOS_START - 10'd1)
      else report_problem("o_slice_ready rose on a column other than the one after hpos 599");
    exp_rgb = expected_pixel(exp_h, exp_v);
    assert (o_rgb == exp_rgb)
      else report_mismatch($sformatf("pixel line %0d col %0d", exp_v, exp_h), exp_rgb, o_rgb);
  endtask

  // Flash model sends one nibble per step with the low nibble first
  task automatic drive_flash;
    raycast_pkg::pos_t s;
    int                k;
    logic [7:0]        b;
    s   = exp_h - raycast_pkg::TSPI_HPOS_START;
    rnd = $urandom;
    if (fetched_valid && s >= raycast_pkg::TSPI_PREAMBLE_LEN &&
        s < raycast_pkg::TSPI_STREAM_LEN) begin
      k        = int'(s - raycast_pkg::TSPI_PREAMBLE_LEN) / 2;
      b        = rec_tex[fetched_idx][k];
      i_tex_in = s[0] ? b[7:4] : b[3:0];
    end else begin
      // Idle bus carries noise so stray captures show up
      i_tex_in = rnd[3:0];
    end
  endtask

  task automatic step_cycle;
    logic fire;
    fire       = i_slice_valid && o_slice_ready;
    last_ready = o_slice_ready;
    prev_h     = exp_h;
    @(negedge clk);
    #2;
    // Flash clock high while clk is low
    assert (o_tex_sclk == 1'b1) else report_mismatch("tex_sclk", 1, int'(o_tex_sclk));
    @(posedge clk);
    #2;
    if (fire) begin
      next_full = 1'b1;
      next_idx  = offer_idx;
      accepted  = 1'b1;
    end else if (prev_h == raycast_pkg::TSPI_HPOS_START - 10'd1 && next_full) begin
      fetched_valid = 1'b1;
      fetched_idx   = next_idx;
      next_full     = 1'b0;
    end
    if (prev_h == raycast_pkg::H_TOTAL - 10'd1) begin
      // Slice streamed on this line is drawn on the next
      cur_valid = fetched_valid;
      cur_idx   = fetched_idx;
      exp_h     = '0;
      exp_v     = (exp_v == raycast_pkg::V_TOTAL - 10'd1) ? '0 : exp_v + 10'd1;
      line_count++;
    end else begin
      exp_h = exp_h + 10'd1;
    end
    check_outputs();
    drive_flash();
  endtask

  task automatic offer_slice(input int r);
    int wait_cycles;
    offer_idx        = r;
    i_slice_wall     = rec_wall[r];
    i_slice_side     = rec_side[r];
    i_slice_texu     = rec_texu[r];
    i_slice_size     = rec_size[r];
    i_slice_texa     = rec_texa[r];
    i_slice_texvinit = rec_vinit[r];
    i_slice_valid    = 1'b1;
    accepted         = 1'b0;
    wait_cycles      = 0;
    while (!accepted) begin
      step_cycle();
      wait_cycles++;
      if (wait_cycles > ACCEPT_TIMEOUT) begin
        report_problem("timeout, slice descriptor was never accepted");
      end
    end
    i_slice_valid = 1'b0;
  endtask

  initial begin
    int gap;
    int r;
    int i;
    int wait_cycles;
    rnd              = $urandom(32'hfd388ada);
    reset            = 1'b1;
    i_slice_valid    = 1'b0;
    i_slice_wall     = '0;
    i_slice_side     = 1'b0;
    i_slice_texu     = '0;
    i_slice_size     = '0;
    i_slice_texa     = '0;
    i_slice_texvinit = '0;
    i_tex_in         = '0;
    exp_h            = '0;
    exp_v            = '0;
    prev_h           = '0;
    line_count       = 0;
    next_full        = 1'b0;
    next_idx         = 0;
    fetched_valid    = 1'b0;
    fetched_idx      = 0;
    cur_valid        = 1'b0;
    cur_idx          = 0;
    offer_idx        = 0;
    accepted         = 1'b0;
    last_ready       = 1'b1;
    out_bits         = '0;
    load_stim();
    i_sky   = sky_rgb;
    i_floor = floor_rgb;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    // First cycle out of reset has counters at 0 and nothing fetched
    assert (o_tex_csb == 1'b1) else report_problem("o_tex_csb is not high after reset");
    assert (o_slice_ready == 1'b1) else report_problem("o_slice_ready is not high after reset");
    check_outputs();
    drive_flash();
    for (r = 0; r < NUM_REC; r++) begin
      rnd = $urandom;
      gap = int'(rnd % 32'd1500);
      // Long pause before the third slice so earlier lines repeat
      if (r == 2) begin
        gap = gap + 3 * int'(raycast_pkg::H_TOTAL);
      end
      for (i = 0; i < gap; i++) begin
        step_cycle();
      end
      offer_slice(r);
    end
    wait_cycles = 0;
    while (line_count < RUN_LINES) begin
      step_cycle();
      wait_cycles++;
      if (wait_cycles > RUN_TIMEOUT) begin
        report_problem("timeout, frame did not complete");
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule
